// ==== src/phy_timing_pkg.sv ====
// PHY reset timing
// Cycle counts for the transceiver reset windows, the internal
// reset timer and the transmit recalibration pulse, plus counter widths.

`default_nettype none

package phy_timing_pkg;

    // transmit PMA reset window
    localparam int unsigned TX_PMA_RESET_CYCLES = 1;

    // receive side, in the order the transceiver runs them
    localparam int unsigned RX_PMA_RESET_CYCLES      = 17;
    localparam int unsigned RX_CDR_PH_RESET_CYCLES   = 1;
    localparam int unsigned RX_CDR_FREQ_RESET_CYCLES = 1;
    localparam int unsigned RX_DFE_LPM_RESET_CYCLES  = 15;
    localparam int unsigned RX_ISCAN_RESET_CYCLES    = 1;

    localparam int unsigned RX_EYE_RESET_CYCLES = RX_PMA_RESET_CYCLES
                                                + RX_CDR_PH_RESET_CYCLES
                                                + RX_CDR_FREQ_RESET_CYCLES
                                                + RX_DFE_LPM_RESET_CYCLES
                                                + RX_ISCAN_RESET_CYCLES;

    // internal reset timer stops here
    localparam int unsigned INT_RST_TIMER_LIMIT = 8;

    // partial transmit reset after OOB
    localparam int unsigned TX_PCS_RESET_CYCLES = 8;

    localparam int unsigned RX_EYE_CNT_W  = 7;
    localparam int unsigned TX_PMA_CNT_W  = 3;
    localparam int unsigned INT_RST_CNT_W = 4;
    localparam int unsigned TX_PCS_CNT_W  = 4;

endpackage

`default_nettype wire

// ==== src/phy_word_pkg.sv ====
// PHY word types
// Geometry of the 4-byte fabric word and the packed structs that
// carry receive lanes, transmit words and link-layer receive words.

`default_nettype none

package phy_word_pkg;

    localparam int unsigned BYTE_W  = 8;
    localparam int unsigned LANES   = 4;
    localparam int unsigned WORD_W  = BYTE_W * LANES;
    localparam int unsigned SHIFT_W = 2;

    // one decoded byte as the transceiver hands it over
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              k;
        logic              comma;
        logic              disp_err;
        logic              not_in_table;
    } rx_lane_t;

    // lane 0 is the first byte on the wire
    typedef struct packed {
        rx_lane_t [LANES-1:0] lane;
    } rx_word_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic [LANES-1:0]  k;
    } tx_word_t;

    // aligned word toward the link layer
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic [LANES-1:0]  k;
        logic [LANES-1:0]  err;
    } ll_rx_t;

endpackage

`default_nettype wire

// ==== src/phy_reset_ctrl.sv ====
// PHY reset controller
// Sequences the transceiver transmit and receive resets, raises the
// user-ready levels, generates the internal PHY reset once the clocks
// are locked and stretches a recalibration request into a TX PCS reset.

`timescale 1ns/1ps
`default_nettype none

module phy_reset_ctrl
(
    input  logic clk,
    input  logic extrst,
    input  logic cpll_lock,
    input  logic usrpll_locked,
    input  logic rx_reset_done,
    input  logic tx_reset_done,
    input  logic tx_pcs_reset_req,
    output logic gtx_rx_reset,
    output logic gtx_tx_reset,
    output logic rx_user_rdy,
    output logic tx_user_rdy,
    output logic gtx_ready,
    output logic phy_rst,
    output logic tx_pcs_reset,
    output logic recal_tx_done
);

    import phy_timing_pkg::*;

    localparam logic [TX_PMA_CNT_W-1:0]  TX_PMA_END  = TX_PMA_CNT_W'(TX_PMA_RESET_CYCLES);
    localparam logic [RX_EYE_CNT_W-1:0]  RX_EYE_END  = RX_EYE_CNT_W'(RX_EYE_RESET_CYCLES);
    localparam logic [INT_RST_CNT_W-1:0] INT_RST_END = INT_RST_CNT_W'(INT_RST_TIMER_LIMIT);
    localparam logic [TX_PCS_CNT_W-1:0]  TX_PCS_END  = TX_PCS_CNT_W'(TX_PCS_RESET_CYCLES);

    logic [TX_PMA_CNT_W-1:0]  tx_pma_cnt;
    logic [RX_EYE_CNT_W-1:0]  rx_eye_cnt;
    logic [INT_RST_CNT_W-1:0] int_rst_timer;
    logic [TX_PCS_CNT_W-1:0]  tx_pcs_cnt;

    logic tx_pma_done;
    logic rx_eye_done;
    logic int_rst_active;
    logic tx_pcs_stop;

    // both transceiver halves held while the channel PLL is unlocked
    assign gtx_tx_reset = extrst | ~cpll_lock;
    assign gtx_rx_reset = extrst | ~cpll_lock;

    assign tx_pma_done = (tx_pma_cnt == TX_PMA_END);
    assign rx_eye_done = (rx_eye_cnt == RX_EYE_END);

    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            tx_pma_cnt <= '0;
        else if (gtx_tx_reset)
            tx_pma_cnt <= '0;
        else if (!tx_pma_done)
            tx_pma_cnt <= tx_pma_cnt + 1'b1;
    end

    // receive window covers PMA, CDR, DFE and eye-scan resets back to back
    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            rx_eye_cnt <= '0;
        else if (gtx_rx_reset)
            rx_eye_cnt <= '0;
        else if (!rx_eye_done)
            rx_eye_cnt <= rx_eye_cnt + 1'b1;
    end

    assign tx_user_rdy = tx_pma_done & usrpll_locked & cpll_lock & ~extrst;
    assign rx_user_rdy = rx_eye_done & usrpll_locked & cpll_lock & ~extrst;

    assign gtx_ready = rx_user_rdy & tx_user_rdy & rx_reset_done & tx_reset_done;

    // internal reset timer, restarts whenever a lock is lost
    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            int_rst_timer <= '0;
        else if (!cpll_lock || !usrpll_locked)
            int_rst_timer <= '0;
        else if (int_rst_timer != INT_RST_END)
            int_rst_timer <= int_rst_timer + 1'b1;
    end

    assign int_rst_active = (int_rst_timer != '0) && (int_rst_timer < INT_RST_END);

    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            phy_rst <= 1'b0;
        else
            phy_rst <= int_rst_active;
    end

    // recalibration stretch
    assign tx_pcs_stop = (tx_pcs_cnt == TX_PCS_END);

    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            tx_pcs_cnt <= '0;
        else if (phy_rst || !tx_pcs_reset_req)
            tx_pcs_cnt <= '0;
        else if (!tx_pcs_stop)
            tx_pcs_cnt <= tx_pcs_cnt + 1'b1;
    end

    assign tx_pcs_reset  = tx_pcs_reset_req & ~tx_pcs_stop & ~extrst;
    assign recal_tx_done = tx_pcs_stop & gtx_ready;

endmodule

`default_nettype wire

// ==== src/comma_shift_detect.sv ====
// Comma shift detector
// Watches the per-lane comma flags of the raw receive word and keeps
// the byte shift that moves the latest comma into lane 0.

`timescale 1ns/1ps
`default_nettype none

module comma_shift_detect
(
    input  logic                             clk,
    input  logic                             extrst,
    input  logic                             phy_rst,
    input  logic [phy_word_pkg::LANES-1:0]   comma,
    output logic [phy_word_pkg::SHIFT_W-1:0] shift
);

    logic two_byte_shift;
    logic one_byte_shift;

    // upper half of the word means a shift of two bytes
    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            two_byte_shift <= 1'b0;
        else if (phy_rst)
            two_byte_shift <= 1'b0;
        else if (comma[2] || comma[3])
            two_byte_shift <= 1'b1;
        else if (comma[0] || comma[1])
            two_byte_shift <= 1'b0;
    end

    // odd lanes need the extra single byte
    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            one_byte_shift <= 1'b0;
        else if (phy_rst)
            one_byte_shift <= 1'b0;
        else if (comma[1] || comma[3])
            one_byte_shift <= 1'b1;
        else if (comma[0] || comma[2])
            one_byte_shift <= 1'b0;
    end

    // no comma in the word keeps the old alignment
    assign shift = {two_byte_shift, one_byte_shift};

endmodule

`default_nettype wire

// ==== src/rx_byte_aligner.sv ====
// Receive byte aligner
// Keeps the previous raw word and selects four consecutive bytes from
// the previous and current words by the comma shift, then packs data,
// K flags and byte error flags for the link layer.

`timescale 1ns/1ps
`default_nettype none

module rx_byte_aligner
(
    input  logic                             clk,
    input  logic                             extrst,
    input  phy_word_pkg::rx_word_t           gtx_rx,
    input  logic [phy_word_pkg::SHIFT_W-1:0] shift,
    output phy_word_pkg::ll_rx_t             ll_rx
);

    import phy_word_pkg::*;

    rx_word_t                 prev_word;
    rx_lane_t [2*LANES-1:0]   window;
    rx_lane_t [LANES-1:0]     picked;

    always_ff @(posedge clk or posedge extrst)
    begin
        if (extrst)
            prev_word <= '0;
        else
            prev_word <= gtx_rx;
    end

    // previous word in lanes 0..3, current word in lanes 4..7
    assign window = {gtx_rx.lane, prev_word.lane};

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            picked[i] = window[i + int'(shift)];
        end
    end

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            ll_rx.data[i*BYTE_W +: BYTE_W] = picked[i].data;
            ll_rx.k[i]                     = picked[i].k;
            // either decoder error marks the byte bad
            ll_rx.err[i]                   = picked[i].disp_err | picked[i].not_in_table;
        end
    end

endmodule

`default_nettype wire

// ==== src/sata_phy_fabric.sv ====
// SATA device PHY, fabric side
// Reset and ready sequencing for the serial transceiver, transmit
// stream selection between OOB and link layer, and receive word
// alignment on commas.

`timescale 1ns/1ps
`default_nettype none

module sata_phy_fabric
(
    input  logic                   clk,
    input  logic                   extrst,
    input  logic                   cpll_lock,
    input  logic                   usrpll_locked,
    input  logic                   rx_reset_done,
    input  logic                   tx_reset_done,
    input  logic                   link_up,
    input  logic                   tx_pcs_reset_req,
    input  phy_word_pkg::rx_word_t gtx_rx,
    input  phy_word_pkg::tx_word_t oob_tx,
    input  phy_word_pkg::tx_word_t ll_tx,
    output phy_word_pkg::tx_word_t gtx_tx,
    output phy_word_pkg::ll_rx_t   ll_rx,
    output logic                   gtx_rx_reset,
    output logic                   gtx_tx_reset,
    output logic                   rx_user_rdy,
    output logic                   tx_user_rdy,
    output logic                   gtx_ready,
    output logic                   phy_rst,
    output logic                   tx_pcs_reset,
    output logic                   recal_tx_done
);

    import phy_word_pkg::*;

    logic [LANES-1:0]   rx_comma;
    logic [SHIFT_W-1:0] rx_shift;

    // link layer owns the line once OOB is through
    assign gtx_tx = link_up ? ll_tx : oob_tx;

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            rx_comma[i] = gtx_rx.lane[i].comma;
        end
    end

    phy_reset_ctrl u_reset_ctrl
    (
        .clk              (clk),
        .extrst           (extrst),
        .cpll_lock        (cpll_lock),
        .usrpll_locked    (usrpll_locked),
        .rx_reset_done    (rx_reset_done),
        .tx_reset_done    (tx_reset_done),
        .tx_pcs_reset_req (tx_pcs_reset_req),
        .gtx_rx_reset     (gtx_rx_reset),
        .gtx_tx_reset     (gtx_tx_reset),
        .rx_user_rdy      (rx_user_rdy),
        .tx_user_rdy      (tx_user_rdy),
        .gtx_ready        (gtx_ready),
        .phy_rst          (phy_rst),
        .tx_pcs_reset     (tx_pcs_reset),
        .recal_tx_done    (recal_tx_done)
    );

    comma_shift_detect u_comma_detect
    (
        .clk     (clk),
        .extrst  (extrst),
        .phy_rst (phy_rst),
        .comma   (rx_comma),
        .shift   (rx_shift)
    );

    rx_byte_aligner u_aligner
    (
        .clk    (clk),
        .extrst (extrst),
        .gtx_rx (gtx_rx),
        .shift  (rx_shift),
        .ll_rx  (ll_rx)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
// Testbench clock generator
// Free-running clock with a fixed period, starting low.

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
#(
    parameter real PERIOD_NS = 40.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_sata_phy_fabric.sv ====
// SATA PHY fabric testbench
// Runs the reset and ready sequence, the internal reset pulse, the
// transmit selector, comma alignment and the recalibration pulse
// against expected values from the timing and alignment rules.

`timescale 1ns/1ps
`default_nettype none

module tb_sata_phy_fabric;

    import phy_timing_pkg::*;
    import phy_word_pkg::*;

    localparam int MAX_CYCLES  = 2000;
    localparam int RST_CYCLES  = 8;
    localparam int ALIGN_WORDS = 6;

    logic clk, extrst, cpll_lock, usrpll_locked, rx_reset_done, tx_reset_done;
    logic link_up, tx_pcs_reset_req;
    logic gtx_rx_reset, gtx_tx_reset, rx_user_rdy, tx_user_rdy, gtx_ready;
    logic phy_rst, tx_pcs_reset, recal_tx_done;
    rx_word_t gtx_rx;
    tx_word_t oob_tx, ll_tx, gtx_tx;
    ll_rx_t   ll_rx;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int test_errors = 0;
    int cycle_count = 0;

    tb_clk_gen #(.PERIOD_NS(40.0)) u_clk_gen (.clk(clk));

    sata_phy_fabric u_dut
    (
        .clk(clk), .extrst(extrst), .cpll_lock(cpll_lock), .usrpll_locked(usrpll_locked),
        .rx_reset_done(rx_reset_done), .tx_reset_done(tx_reset_done), .link_up(link_up),
        .tx_pcs_reset_req(tx_pcs_reset_req), .gtx_rx(gtx_rx), .oob_tx(oob_tx),
        .ll_tx(ll_tx), .gtx_tx(gtx_tx), .ll_rx(ll_rx), .gtx_rx_reset(gtx_rx_reset),
        .gtx_tx_reset(gtx_tx_reset), .rx_user_rdy(rx_user_rdy), .tx_user_rdy(tx_user_rdy),
        .gtx_ready(gtx_ready), .phy_rst(phy_rst), .tx_pcs_reset(tx_pcs_reset),
        .recal_tx_done(recal_tx_done)
    );

    // held in reset while the external reset is up or the channel PLL is unlocked
    held_in_reset: assert property (@(posedge clk) (extrst || !cpll_lock) |->
        (gtx_rx_reset && gtx_tx_reset && !rx_user_rdy && !tx_user_rdy && !gtx_ready))
    else
    begin
        error_count++;
        $display("transceiver resets or ready levels wrong while held in reset");
    end

    quiet_in_reset: assert property (@(posedge clk) extrst |->
        (!phy_rst && !tx_pcs_reset && !recal_tx_done))
    else
    begin
        error_count++;
        $display("phy_rst, tx_pcs_reset or recal_tx_done high during extrst");
    end

    ready_rule: assert property (@(posedge clk)
        gtx_ready == (rx_user_rdy && tx_user_rdy && rx_reset_done && tx_reset_done))
    else
    begin
        error_count++;
        $display("mismatch gtx_ready: got %h, expected %h", $sampled(gtx_ready),
                 $sampled(rx_user_rdy && tx_user_rdy && rx_reset_done && tx_reset_done));
    end

    tx_select: assert property (@(posedge clk) gtx_tx == (link_up ? ll_tx : oob_tx))
    else
    begin
        error_count++;
        $display("mismatch gtx_tx: got %h, expected %h", $sampled(gtx_tx),
                 $sampled(link_up ? ll_tx : oob_tx));
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout, run still going after %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            error_count++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (error_count == test_errors) ? "ok" : "errors seen");
        test_errors = error_count;
    endtask

    // timer holds min(n-1, limit) before edge n; phy_rst follows one edge later
    function automatic logic phy_rst_after(input int n);
        int timer;
        timer = (n < 1) ? 0 : n - 1;
        if (timer > int'(INT_RST_TIMER_LIMIT))
            timer = int'(INT_RST_TIMER_LIMIT);
        return (timer >= 1) && (timer < int'(INT_RST_TIMER_LIMIT));
    endfunction

    function automatic rx_lane_t random_lane();
        rx_lane_t b;
        b = '0;
        b.data = 8'($urandom);
        b.k    = ($urandom % 8) == 0;
        return b;
    endfunction

    function automatic tx_word_t random_tx();
        tx_word_t w;
        w.data = $urandom;
        w.k    = 4'($urandom);
        return w;
    endfunction

    // lanes 0..3 from the older word, 4..7 from the newer, window starts at s
    function automatic ll_rx_t expected_ll(input rx_word_t older, input rx_word_t newer,
                                           input int s);
        rx_lane_t stream [2*LANES];
        rx_lane_t b;
        ll_rx_t   r;
        for (int i = 0; i < LANES; i++)
        begin
            stream[i]         = older.lane[i];
            stream[i + LANES] = newer.lane[i];
        end
        for (int i = 0; i < LANES; i++)
        begin
            b = stream[i + s];
            r.data[i*BYTE_W +: BYTE_W] = b.data;
            r.k[i]   = b.k;
            r.err[i] = b.disp_err | b.not_in_table;
        end
        return r;
    endfunction

    initial
    begin
        rx_word_t word;
        rx_word_t prev_word;
        int       high_cycles;

        void'($urandom(51));
        extrst = 1'b1;
        cpll_lock = 1'b0;
        usrpll_locked = 1'b0;
        rx_reset_done = 1'b0;
        tx_reset_done = 1'b0;
        link_up = 1'b0;
        // request up during external reset, the pulse must not appear
        tx_pcs_reset_req = 1'b1;
        gtx_rx = '0;
        oob_tx = '0;
        ll_tx = '0;

        for (int n = 0; n < RST_CYCLES; n++)
        begin
            next_cycle();
            check_val("gtx_rx_reset", gtx_rx_reset, 1'b1);
            check_val("gtx_tx_reset", gtx_tx_reset, 1'b1);
            check_val("phy_rst", phy_rst, 1'b0);
            check_val("tx_pcs_reset", tx_pcs_reset, 1'b0);
        end
        extrst = 1'b0;
        tx_pcs_reset_req = 1'b0;
        for (int n = 0; n < 3; n++)
        begin
            next_cycle();
            check_val("gtx_rx_reset", gtx_rx_reset, 1'b1);
            check_val("tx_user_rdy", tx_user_rdy, 1'b0);
            check_val("phy_rst", phy_rst, 1'b0);
        end
        cpll_lock = 1'b1;
        usrpll_locked = 1'b1;
        #1;
        check_val("gtx_rx_reset", gtx_rx_reset, 1'b0);
        check_val("gtx_tx_reset", gtx_tx_reset, 1'b0);
        check_val("tx_user_rdy", tx_user_rdy, 1'b0);
        for (int n = 1; n <= 40; n++)
        begin
            next_cycle();
            check_val("tx_user_rdy", tx_user_rdy, n >= int'(TX_PMA_RESET_CYCLES));
            check_val("rx_user_rdy", rx_user_rdy, n >= int'(RX_EYE_RESET_CYCLES));
            check_val("phy_rst", phy_rst, phy_rst_after(n));
        end
        end_test("reset and ready sequence");

        next_cycle();
        usrpll_locked = 1'b0;
        #1;
        check_val("rx_user_rdy", rx_user_rdy, 1'b0);
        check_val("tx_user_rdy", tx_user_rdy, 1'b0);
        for (int n = 0; n < 4; n++)
        begin
            next_cycle();
            check_val("phy_rst", phy_rst, 1'b0);
        end
        usrpll_locked = 1'b1;
        #1;
        // receive window was not reopened, so both levels return at once
        check_val("rx_user_rdy", rx_user_rdy, 1'b1);
        check_val("tx_user_rdy", tx_user_rdy, 1'b1);
        high_cycles = 0;
        for (int n = 1; n <= 14; n++)
        begin
            next_cycle();
            check_val("phy_rst", phy_rst, phy_rst_after(n));
            high_cycles += int'(phy_rst);
        end
        check_val("phy_rst high cycles", high_cycles, 7);
        end_test("internal reset pulse");

        for (int n = 0; n < 20; n++)
        begin
            next_cycle();
            rx_reset_done = (n < 4) ? n[0] : 1'($urandom);
            tx_reset_done = (n < 4) ? n[1] : 1'($urandom);
            #1;
            check_val("gtx_ready", gtx_ready, rx_reset_done & tx_reset_done);
        end
        next_cycle();
        rx_reset_done = 1'b1;
        tx_reset_done = 1'b1;
        end_test("transceiver ready");

        for (int n = 0; n < 32; n++)
        begin
            next_cycle();
            link_up = 1'($urandom);
            oob_tx = random_tx();
            ll_tx = random_tx();
            #1;
            check_val("gtx_tx", gtx_tx, link_up ? ll_tx : oob_tx);
        end
        end_test("transmit selector");

        // downward order so every shift bit is both set and cleared
        for (int k = LANES - 1; k >= 0; k--)
        begin
            next_cycle();
            for (int i = 0; i < LANES; i++)
                word.lane[i] = random_lane();
            word.lane[k].data  = 8'hbc;
            word.lane[k].k     = 1'b1;
            word.lane[k].comma = 1'b1;
            gtx_rx = word;
            prev_word = word;
            for (int m = 1; m <= ALIGN_WORDS; m++)
            begin
                next_cycle();
                for (int i = 0; i < LANES; i++)
                    word.lane[i] = random_lane();
                if (m % 2 == 0)
                    word.lane[m % LANES].disp_err = 1'b1;
                else
                    word.lane[(m + k) % LANES].not_in_table = 1'b1;
                gtx_rx = word;
                #1;
                check_val($sformatf("ll_rx shift %0d", k), ll_rx,
                          expected_ll(prev_word, word, k));
                prev_word = word;
            end
        end
        end_test("comma alignment");

        next_cycle();
        tx_pcs_reset_req = 1'b1;
        #1;
        check_val("tx_pcs_reset", tx_pcs_reset, 1'b1);
        high_cycles = 1;
        for (int n = 1; n <= 12; n++)
        begin
            next_cycle();
            check_val("tx_pcs_reset", tx_pcs_reset, n < int'(TX_PCS_RESET_CYCLES));
            check_val("recal_tx_done", recal_tx_done, n >= int'(TX_PCS_RESET_CYCLES));
            high_cycles += int'(tx_pcs_reset);
        end
        check_val("tx_pcs_reset high cycles", high_cycles, TX_PCS_RESET_CYCLES);
        rx_reset_done = 1'b0;
        #1;
        check_val("recal_tx_done", recal_tx_done, 1'b0);
        next_cycle();
        rx_reset_done = 1'b1;
        tx_pcs_reset_req = 1'b0;
        #1;
        // stretch counter only clears at the next edge
        check_val("tx_pcs_reset", tx_pcs_reset, 1'b0);
        check_val("recal_tx_done", recal_tx_done, 1'b1);
        next_cycle();
        check_val("recal_tx_done", recal_tx_done, 1'b0);
        end_test("recalibration pulse");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/phy_timing_pkg.sv
src/phy_word_pkg.sv
src/phy_reset_ctrl.sv
src/comma_shift_detect.sv
src/rx_byte_aligner.sv
src/sata_phy_fabric.sv
tests/tb_clk_gen.sv
tests/tb_sata_phy_fabric.sv
